/* Makefile */
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert -Wno-fatal
TOP := mem_tb
FILELIST := build.f

OBJ_DIR := obj_dir
BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard *.sv *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

/* build.f */
+incdir+.
uop_pkg.sv
dcache_pkg.sv
credit_fifo.sv
mem_stage.sv
mem_cfg.sv
dcache.sv
mem_top.sv
mem_properties.sv
mem_tb.sv

/* credit_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module credit_fifo #(
	parameter type payload_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic push,
	input wire payload_t push_data,
	input wire logic pop,
	output payload_t pop_data,
	output logic empty,
	output logic credit
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	payload_t entries [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;

	assign empty = (count == '0);
	assign pop_data = entries[rd_ptr]; // head is visible before the pop.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			credit <= pop; // one credit back per dequeued entry.
			if (push) begin
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			count <= count + CNT_W'(push) - CNT_W'(pop);
		end
	end

	// storage, the sender never pushes into a full queue.
	always_ff @(posedge clk) begin
		if (push) begin
			entries[wr_ptr] <= push_data;
		end
	end

endmodule

`default_nettype wire

/* dcache.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module dcache (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic q_empty,
	input wire dcache_pkg::dc_req_t q_data,
	output logic q_pop,
	output logic dc_done,
	output logic [`MEM_DATA_W-1:0] dc_rdata
);

	localparam int IDX_W = $clog2(`DC_LINES);
	localparam int WORD_W = $clog2(`DC_MEM_WORDS);
	localparam int TAG_W = `MEM_ADDR_W - IDX_W - 3;
	localparam int LAT_W = $clog2(`DC_MISS_LAT + 1);

	typedef enum logic {
		DC_IDLE,
		DC_BUSY
	} state_t;

	state_t state;
	logic [LAT_W-1:0] wait_cnt;
	dcache_pkg::dc_req_t req_r; // request being served.

	logic [`DC_LINES-1:0] line_valid;
	logic [TAG_W-1:0] line_tag [`DC_LINES];
	logic [`MEM_DATA_W-1:0] line_data [`DC_LINES];
	logic [`MEM_DATA_W-1:0] backing [`DC_MEM_WORDS];

	logic [IDX_W-1:0] q_idx;
	logic [TAG_W-1:0] q_tag;
	logic [IDX_W-1:0] r_idx;
	logic [TAG_W-1:0] r_tag;
	logic [WORD_W-1:0] r_word;
	logic hit_in;
	logic hit_r;
	logic complete;

	assign q_idx = q_data.addr[3 +: IDX_W];
	assign q_tag = q_data.addr[`MEM_ADDR_W-1 -: TAG_W];
	assign r_idx = req_r.addr[3 +: IDX_W];
	assign r_tag = req_r.addr[`MEM_ADDR_W-1 -: TAG_W];
	assign r_word = req_r.addr[3 +: WORD_W]; // higher bits alias.

	assign hit_in = line_valid[q_idx] && (line_tag[q_idx] == q_tag);
	assign hit_r = line_valid[r_idx] && (line_tag[r_idx] == r_tag);
	assign q_pop = (state == DC_IDLE) && !q_empty;
	assign complete = (state == DC_BUSY) && (wait_cnt == LAT_W'(1));

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= DC_IDLE;
			wait_cnt <= '0;
			dc_done <= 1'b0;
			line_valid <= '0;
		end else begin
			dc_done <= 1'b0;
			if (q_pop) begin
				if (q_data.cmd == dcache_pkg::DC_FLUSH) begin
					line_valid[q_idx] <= 1'b0;
					dc_done <= 1'b1;
				end else if (q_data.cmd == dcache_pkg::DC_READ && hit_in) begin
					dc_done <= 1'b1; // hit answers next cycle.
				end else begin
					state <= DC_BUSY;
					wait_cnt <= LAT_W'(`DC_MISS_LAT - 1);
				end
			end else if (complete) begin
				state <= DC_IDLE;
				dc_done <= 1'b1;
				if (req_r.cmd == dcache_pkg::DC_READ) line_valid[r_idx] <= 1'b1;
			end else if (state == DC_BUSY) begin
				wait_cnt <= wait_cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (q_pop) begin
			req_r <= q_data;
			if (q_data.cmd == dcache_pkg::DC_READ && hit_in) dc_rdata <= line_data[q_idx];
		end
		if (complete && req_r.cmd == dcache_pkg::DC_READ) begin
			line_tag[r_idx] <= r_tag; // miss fill.
			line_data[r_idx] <= backing[r_word];
			dc_rdata <= backing[r_word];
		end
		if (complete && req_r.cmd == dcache_pkg::DC_WRITE && hit_r) begin
			line_data[r_idx] <= req_r.wdata; // write-through, no allocate.
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < `DC_MEM_WORDS; i++) backing[i] <= '0;
		end else if (complete && req_r.cmd == dcache_pkg::DC_WRITE) begin
			backing[r_word] <= req_r.wdata;
		end
	end

endmodule

`default_nettype wire

/* dcache_pkg.sv */
`include "mem_consts.svh"
`default_nettype none

package dcache_pkg;

	typedef enum logic [1:0] {
		DC_READ = 2'd0,
		DC_WRITE = 2'd1,
		DC_FLUSH = 2'd2
	} dc_cmd_t;

	// one request to the data cache.
	typedef struct packed {
		dc_cmd_t cmd;
		logic [`MEM_ADDR_W-1:0] addr;
		logic [`MEM_DATA_W-1:0] wdata; // only meaningful for writes.
	} dc_req_t;

endpackage

`default_nettype wire

/* mem_cfg.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module mem_cfg (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic cfg_wr,
	input wire logic [1:0] cfg_addr,
	input wire logic [`MEM_DATA_W-1:0] cfg_wdata,
	output logic [`MEM_DATA_W-1:0] cfg_rdata,
	input wire logic cnt_rd,
	input wire logic cnt_wr,
	input wire logic cnt_fl,
	output logic [`MEM_DATA_W-1:0] stack_slot
);

	localparam int CNT_W = 32;

	logic [CNT_W-1:0] rd_count;
	logic [CNT_W-1:0] wr_count;
	logic [CNT_W-1:0] fl_count;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			stack_slot <= `CFG_STACK_SLOT_RST;
			rd_count <= '0;
			wr_count <= '0;
			fl_count <= '0;
		end else begin
			if (cfg_wr && cfg_addr == 2'd0) begin
				stack_slot <= cfg_wdata; // only writable register.
			end
			if (cnt_rd) rd_count <= rd_count + 1'b1;
			if (cnt_wr) wr_count <= wr_count + 1'b1;
			if (cnt_fl) fl_count <= fl_count + 1'b1;
		end
	end

	// counters read back zero-extended.
	always_comb begin
		case (cfg_addr)
			2'd0: cfg_rdata = stack_slot;
			2'd1: cfg_rdata = {{(`MEM_DATA_W - CNT_W){1'b0}}, rd_count};
			2'd2: cfg_rdata = {{(`MEM_DATA_W - CNT_W){1'b0}}, wr_count};
			default: cfg_rdata = {{(`MEM_DATA_W - CNT_W){1'b0}}, fl_count};
		endcase
	end

endmodule

`default_nettype wire

/* mem_consts.svh */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

`default_nettype none

`define MEM_ADDR_W 64 // address width.
`define MEM_DATA_W 64 // data word width.
`define MEM_RES_W 128 // alu and writeback result width.
`define OPC_W 10
`define REG_W 4

`define OPC_LEA 10'h08d
`define OPC_CLFLUSH 10'h1ae

`define IN_DEPTH 4 // input queue entries, also producer credits.
`define REQ_DEPTH 2 // request queue entries, also stage credits.

`define DC_LINES 16
`define DC_MEM_WORDS 256 // backing words, address bits 10 to 3.
`define DC_MISS_LAT 4 // cycles for a read miss or a write.

`define CFG_STACK_SLOT_RST 64'd8

`default_nettype wire

`endif

/* mem_properties.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module mem_properties (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_valid,
	input wire logic in_credit,
	input wire logic req_valid,
	input wire logic req_credit,
	input wire logic dc_done,
	input wire logic wb_valid
);

	int req_credits; // mirror of the stage's request credits.
	int prod_credits; // credits the producer holds.
	logic req_outstanding;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			req_credits <= `REQ_DEPTH;
			prod_credits <= `IN_DEPTH;
			req_outstanding <= 1'b0;
		end else begin
			req_credits <= req_credits - int'(req_valid) + int'(req_credit);
			prod_credits <= prod_credits - int'(in_valid) + int'(in_credit);
			if (req_valid) begin
				req_outstanding <= 1'b1;
			end else if (dc_done) begin
				req_outstanding <= 1'b0;
			end
		end
	end

	req_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		req_credits <= `REQ_DEPTH)
		else $error("request credits above request queue depth");

	done_needs_request: assert property (@(posedge clk) disable iff (!arst_n)
		dc_done |-> req_outstanding)
		else $error("dc_done without an outstanding request");

	// a credit returned in this cycle is already usable.
	valid_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
		in_valid |-> (prod_credits > 0 || in_credit))
		else $error("in_valid asserted with no producer credit");

	wb_quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> !wb_valid)
		else $error("wb_valid high during reset");

endmodule

bind mem_top mem_properties mem_properties_inst (
	.clk(clk),
	.arst_n(arst_n),
	.in_valid(in_valid),
	.in_credit(in_credit),
	.req_valid(req_valid),
	.req_credit(req_credit),
	.dc_done(dc_done),
	.wb_valid(wb_valid)
);

`default_nettype wire

/* mem_stage.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module mem_stage (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_empty,
	input wire uop_pkg::micro_op_t in_uop,
	input wire logic [`MEM_RES_W-1:0] in_alu_result,
	output logic in_pop,
	output logic req_valid,
	output dcache_pkg::dc_req_t req_data,
	input wire logic req_credit,
	input wire logic dc_done,
	input wire logic [`MEM_DATA_W-1:0] dc_rdata,
	input wire logic [`MEM_DATA_W-1:0] stack_slot,
	output logic cnt_rd,
	output logic cnt_wr,
	output logic cnt_fl,
	output logic wb_valid,
	output logic [`MEM_RES_W-1:0] wb_result,
	output logic [`MEM_ADDR_W-1:0] wb_rip
);

	localparam int CR_W = $clog2(`REQ_DEPTH + 1);

	typedef enum logic {
		ST_IDLE,
		ST_WAIT // one cache request outstanding.
	} state_t;

	state_t state;
	logic [CR_W-1:0] req_credits;
	logic need_mem;
	logic is_load_r;
	logic [`MEM_RES_W-1:0] direct_result;

	// decode of the queue head, first matching rule wins.
	always_comb begin
		need_mem = 1'b0;
		direct_result = in_alu_result;
		req_data.cmd = dcache_pkg::DC_READ;
		req_data.addr = in_uop.oprd2.ext + in_uop.oprd2.value;
		req_data.wdata = in_alu_result[`MEM_DATA_W-1:0];
		if (in_uop.opcode == `OPC_LEA) begin
			direct_result = {{(`MEM_RES_W - `MEM_ADDR_W){1'b0}}, req_data.addr};
		end else if (in_uop.opcode == `OPC_CLFLUSH) begin
			need_mem = 1'b1;
			req_data.cmd = dcache_pkg::DC_FLUSH;
		end else if (in_uop.oprd1.kind == uop_pkg::OPRD_MEM) begin
			need_mem = 1'b1;
			req_data.cmd = dcache_pkg::DC_WRITE;
			req_data.addr = in_uop.oprd1.ext + in_uop.oprd1.value;
		end else if (in_uop.oprd2.kind == uop_pkg::OPRD_MEM) begin
			need_mem = 1'b1;
		end else if (in_uop.oprd1.kind == uop_pkg::OPRD_STACK) begin
			need_mem = 1'b1; // push.
			req_data.cmd = dcache_pkg::DC_WRITE;
			req_data.addr = in_uop.oprd1.ext - stack_slot;
		end else if (in_uop.oprd2.kind == uop_pkg::OPRD_STACK) begin
			need_mem = 1'b1; // pop.
			req_data.addr = in_uop.oprd2.ext;
		end
	end

	// a memory op also needs a request credit before it leaves the queue.
	assign in_pop = (state == ST_IDLE) && !in_empty && (!need_mem || req_credits != '0);
	assign req_valid = in_pop && need_mem;

	assign cnt_rd = req_valid && (req_data.cmd == dcache_pkg::DC_READ);
	assign cnt_wr = req_valid && (req_data.cmd == dcache_pkg::DC_WRITE);
	assign cnt_fl = req_valid && (req_data.cmd == dcache_pkg::DC_FLUSH);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			req_credits <= CR_W'(`REQ_DEPTH);
			wb_valid <= 1'b0;
			is_load_r <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			req_credits <= req_credits - CR_W'(req_valid) + CR_W'(req_credit);
			case (state)
				ST_IDLE: begin
					if (in_pop) begin
						is_load_r <= need_mem && (req_data.cmd == dcache_pkg::DC_READ);
						if (need_mem) begin
							state <= ST_WAIT;
						end else begin
							wb_valid <= 1'b1; // no memory access, retire now.
						end
					end
				end
				ST_WAIT: begin
					if (dc_done) begin
						state <= ST_IDLE;
						wb_valid <= 1'b1;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// writeback payload. stores and flushes keep the alu result taken at the pop.
	always_ff @(posedge clk) begin
		if (in_pop) begin
			wb_rip <= in_uop.next_rip;
			wb_result <= direct_result;
		end else if (state == ST_WAIT && dc_done && is_load_r) begin
			wb_result <= {{(`MEM_RES_W - `MEM_DATA_W){1'b0}}, dc_rdata};
		end
	end

endmodule

`default_nettype wire

/* mem_tb.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module mem_tb;

	localparam int CLK_HALF = 4;
	localparam int SEND_TIMEOUT = 200;
	localparam int DRAIN_TIMEOUT = 1000;

	logic clk;
	logic arst_n;
	logic in_valid;
	uop_pkg::micro_op_t in_uop;
	logic [`MEM_RES_W-1:0] in_alu_result;
	logic in_credit;
	logic cfg_wr;
	logic [1:0] cfg_addr;
	logic [`MEM_DATA_W-1:0] cfg_wdata;
	logic [`MEM_DATA_W-1:0] cfg_rdata;
	logic wb_valid;
	logic [`MEM_RES_W-1:0] wb_result;
	logic [`MEM_ADDR_W-1:0] wb_rip;

	integer seed;
	int errors;
	bit timed_out;
	int credits; // producer side credit count.
	logic [`MEM_DATA_W-1:0] model_mem [`DC_MEM_WORDS];
	logic [`MEM_DATA_W-1:0] model_slot;
	int n_loads;
	int n_stores;
	int n_flushes;
	logic [`MEM_ADDR_W-1:0] rip_ctr;
	logic [`MEM_RES_W-1:0] exp_result [$];
	logic [`MEM_ADDR_W-1:0] exp_rip [$];

	mem_top mem_top_inst (
		.clk(clk), .arst_n(arst_n),
		.in_valid(in_valid), .in_uop(in_uop), .in_alu_result(in_alu_result),
		.in_credit(in_credit),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.wb_valid(wb_valid), .wb_result(wb_result), .wb_rip(wb_rip)
	);

	initial begin
		clk = 1'b0;
		forever #CLK_HALF clk = ~clk;
	end

	function automatic int rand_below(input int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [63:0] rand64();
		return {$random(seed), $random(seed)};
	endfunction

	// small word-aligned range, so repeats hit in the cache.
	function automatic logic [63:0] pick_addr();
		return 64'h100 + 64'(rand_below(24)) * 64'd8;
	endfunction

	function automatic uop_pkg::micro_op_t base_uop();
		uop_pkg::micro_op_t u;
		logic [9:0] opc;
		opc = 10'(rand_below(1024));
		if (opc == `OPC_LEA || opc == `OPC_CLFLUSH) opc = opc ^ 10'h001;
		u.opcode = opc;
		u.oprd1.kind = uop_pkg::oprd_kind_t'(rand_below(2)); // reg or imm only.
		u.oprd1.r = 4'(rand_below(16));
		u.oprd1.ext = rand64();
		u.oprd1.value = rand64();
		u.oprd2.kind = uop_pkg::oprd_kind_t'(rand_below(2));
		u.oprd2.r = 4'(rand_below(16));
		u.oprd2.ext = rand64();
		u.oprd2.value = rand64();
		u.next_rip = rip_ctr;
		rip_ctr = rip_ctr + 64'(1 + rand_below(15));
		return u;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		if (got !== exp) begin
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_timeout(input string what);
		$display("timeout: %s", what);
		errors++;
		timed_out = 1'b1;
	endtask

	task automatic check_writeback();
		logic [`MEM_RES_W-1:0] e_res;
		logic [`MEM_ADDR_W-1:0] e_rip;
		if (exp_result.size() == 0) begin
			$display("writeback arrived with no micro-op pending");
			errors++;
		end else begin
			e_res = exp_result.pop_front();
			e_rip = exp_rip.pop_front();
			check_value("wb_result", wb_result, e_res);
			check_value("wb_rip", {64'h0, wb_rip}, {64'h0, e_rip});
		end
	endtask

	// one cycle, everything on the falling edge.
	task automatic tick();
		@(negedge clk);
		in_valid = 1'b0;
		cfg_wr = 1'b0;
		if (in_credit) credits++;
		if (credits > `IN_DEPTH) begin
			$display("producer credit count went above the input queue depth");
			errors++;
		end
		if (wb_valid) check_writeback();
	endtask

	task automatic idle(input int n);
		repeat (n) tick();
	endtask

	task automatic send(input uop_pkg::micro_op_t u, input logic [127:0] alu,
			input logic [127:0] exp);
		int waited;
		waited = 0;
		tick();
		while (credits == 0 && !timed_out) begin
			tick();
			waited++;
			if (waited >= SEND_TIMEOUT) report_timeout("no input credit came back");
		end
		if (!timed_out) begin
			in_valid = 1'b1;
			in_uop = u;
			in_alu_result = alu;
			credits--;
			exp_result.push_back(exp);
			exp_rip.push_back(u.next_rip);
		end
	endtask

	task automatic drain();
		int waited;
		waited = 0;
		while ((exp_result.size() != 0 || credits != `IN_DEPTH) && !timed_out) begin
			tick();
			waited++;
			if (waited >= DRAIN_TIMEOUT) report_timeout("pending writebacks never arrived");
		end
	endtask

	task automatic send_pass();
		logic [127:0] alu;
		alu = {rand64(), rand64()};
		send(base_uop(), alu, alu);
	endtask

	task automatic send_lea();
		uop_pkg::micro_op_t u;
		u = base_uop();
		u.opcode = `OPC_LEA;
		send(u, {rand64(), rand64()}, {64'h0, u.oprd2.ext + u.oprd2.value});
	endtask

	task automatic send_store(input logic [63:0] addr);
		uop_pkg::micro_op_t u;
		logic [127:0] alu;
		u = base_uop();
		alu = {rand64(), rand64()};
		u.oprd1.kind = uop_pkg::OPRD_MEM;
		u.oprd1.value = 64'(rand_below(8)) * 64'd8;
		u.oprd1.ext = addr - u.oprd1.value;
		model_mem[addr[10:3]] = alu[63:0];
		n_stores++;
		send(u, alu, alu);
	endtask

	task automatic send_load(input logic [63:0] addr);
		uop_pkg::micro_op_t u;
		u = base_uop();
		u.oprd2.kind = uop_pkg::OPRD_MEM;
		u.oprd2.value = 64'(rand_below(8)) * 64'd8;
		u.oprd2.ext = addr - u.oprd2.value;
		n_loads++;
		send(u, {rand64(), rand64()}, {64'h0, model_mem[addr[10:3]]});
	endtask

	task automatic send_push(input logic [63:0] sp);
		uop_pkg::micro_op_t u;
		logic [127:0] alu;
		logic [63:0] addr;
		u = base_uop();
		alu = {rand64(), rand64()};
		u.oprd1.kind = uop_pkg::OPRD_STACK;
		u.oprd1.ext = sp;
		addr = sp - model_slot; // slot taken off before the store.
		model_mem[addr[10:3]] = alu[63:0];
		n_stores++;
		send(u, alu, alu);
	endtask

	task automatic send_pop(input logic [63:0] sp);
		uop_pkg::micro_op_t u;
		u = base_uop();
		u.oprd2.kind = uop_pkg::OPRD_STACK;
		u.oprd2.ext = sp;
		n_loads++;
		send(u, {rand64(), rand64()}, {64'h0, model_mem[sp[10:3]]});
	endtask

	task automatic send_flush(input logic [63:0] addr);
		uop_pkg::micro_op_t u;
		logic [127:0] alu;
		u = base_uop();
		alu = {rand64(), rand64()};
		u.opcode = `OPC_CLFLUSH;
		u.oprd2.kind = uop_pkg::OPRD_MEM;
		u.oprd2.value = 64'(rand_below(8)) * 64'd8;
		u.oprd2.ext = addr - u.oprd2.value;
		n_flushes++;
		send(u, alu, alu);
	endtask

	task automatic send_random_op();
		logic [63:0] a;
		a = pick_addr();
		case (rand_below(8))
			0: send_pass();
			1: send_lea();
			2: send_store(a);
			3: send_load(a);
			4: send_push(a + model_slot);
			5: send_pop(a);
			6: send_flush(a);
			default: begin
				send_load(a); // second one should hit.
				send_load(a);
			end
		endcase
		if (rand_below(4) == 0) idle(rand_below(6)); // gap, otherwise a burst.
	endtask

	task automatic write_cfg(input logic [1:0] a, input logic [63:0] d);
		tick();
		cfg_wr = 1'b1;
		cfg_addr = a;
		cfg_wdata = d;
		tick();
	endtask

	task automatic check_cfg(input logic [1:0] a, input logic [63:0] e, input string name);
		tick();
		cfg_addr = a;
		#1;
		check_value(name, {64'h0, cfg_rdata}, {64'h0, e});
	endtask

	initial begin
		logic [63:0] a;
		seed = 32'h52615029;
		errors = 0;
		timed_out = 1'b0;
		credits = `IN_DEPTH;
		model_slot = `CFG_STACK_SLOT_RST;
		n_loads = 0;
		n_stores = 0;
		n_flushes = 0;
		rip_ctr = 64'h0040_1000;
		for (int i = 0; i < `DC_MEM_WORDS; i++) model_mem[i] = '0;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_uop = '0;
		in_alu_result = '0;
		cfg_wr = 1'b0;
		cfg_addr = 2'd0;
		cfg_wdata = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// non-memory traffic first.
		repeat (40) begin
			if (rand_below(2) == 0) send_pass();
			else send_lea();
			if (rand_below(3) == 0) idle(rand_below(4));
		end
		drain();

		repeat (150) send_random_op();
		drain();

		// flush between store and load keeps the data.
		repeat (6) begin
			a = pick_addr();
			send_load(a);
			send_store(a);
			send_flush(a);
			send_load(a);
		end
		drain();

		// new stack slot, only while the pipeline is empty.
		write_cfg(2'd0, 64'd16);
		model_slot = 64'd16;
		check_cfg(2'd0, 64'd16, "stack_slot");
		repeat (8) begin
			a = pick_addr() + 64'd16;
			send_push(a);
			send_pop(a - 64'd16);
		end
		drain();

		repeat (200) send_random_op();
		drain();

		check_cfg(2'd1, 64'(n_loads), "load_count");
		check_cfg(2'd2, 64'(n_stores), "store_count");
		check_cfg(2'd3, 64'(n_flushes), "flush_count");

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* mem_top.sv */
`timescale 1ns/10ps
`include "mem_consts.svh"
`default_nettype none

module mem_top (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic in_valid,
	input wire uop_pkg::micro_op_t in_uop,
	input wire logic [`MEM_RES_W-1:0] in_alu_result,
	output logic in_credit,
	input wire logic cfg_wr,
	input wire logic [1:0] cfg_addr,
	input wire logic [`MEM_DATA_W-1:0] cfg_wdata,
	output logic [`MEM_DATA_W-1:0] cfg_rdata,
	output logic wb_valid,
	output logic [`MEM_RES_W-1:0] wb_result,
	output logic [`MEM_ADDR_W-1:0] wb_rip
);

	// input queue entry, micro-op with its alu result.
	typedef struct packed {
		uop_pkg::micro_op_t uop;
		logic [`MEM_RES_W-1:0] alu_result;
	} in_entry_t;

	in_entry_t in_push_data;
	in_entry_t in_head;
	logic in_empty;
	logic in_pop;

	logic req_valid;
	dcache_pkg::dc_req_t req_data;
	dcache_pkg::dc_req_t q_data;
	logic req_credit;
	logic q_empty;
	logic q_pop;

	logic dc_done;
	logic [`MEM_DATA_W-1:0] dc_rdata;
	logic [`MEM_DATA_W-1:0] stack_slot;
	logic cnt_rd;
	logic cnt_wr;
	logic cnt_fl;

	assign in_push_data = '{uop: in_uop, alu_result: in_alu_result};

	credit_fifo #(.payload_t(in_entry_t), .DEPTH(`IN_DEPTH)) in_fifo (
		.clk(clk), .arst_n(arst_n),
		.push(in_valid), .push_data(in_push_data),
		.pop(in_pop), .pop_data(in_head),
		.empty(in_empty), .credit(in_credit)
	);

	mem_stage mem_stage_inst (
		.clk(clk), .arst_n(arst_n),
		.in_empty(in_empty), .in_uop(in_head.uop), .in_alu_result(in_head.alu_result),
		.in_pop(in_pop),
		.req_valid(req_valid), .req_data(req_data), .req_credit(req_credit),
		.dc_done(dc_done), .dc_rdata(dc_rdata), .stack_slot(stack_slot),
		.cnt_rd(cnt_rd), .cnt_wr(cnt_wr), .cnt_fl(cnt_fl),
		.wb_valid(wb_valid), .wb_result(wb_result), .wb_rip(wb_rip)
	);

	mem_cfg mem_cfg_inst (
		.clk(clk), .arst_n(arst_n),
		.cfg_wr(cfg_wr), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata),
		.cnt_rd(cnt_rd), .cnt_wr(cnt_wr), .cnt_fl(cnt_fl),
		.stack_slot(stack_slot)
	);

	credit_fifo #(.payload_t(dcache_pkg::dc_req_t), .DEPTH(`REQ_DEPTH)) req_fifo (
		.clk(clk), .arst_n(arst_n),
		.push(req_valid), .push_data(req_data),
		.pop(q_pop), .pop_data(q_data),
		.empty(q_empty), .credit(req_credit)
	);

	dcache dcache_inst (
		.clk(clk), .arst_n(arst_n),
		.q_empty(q_empty), .q_data(q_data), .q_pop(q_pop),
		.dc_done(dc_done), .dc_rdata(dc_rdata)
	);

endmodule

`default_nettype wire

/* uop_pkg.sv */
`include "mem_consts.svh"
`default_nettype none

package uop_pkg;

	// kind of an operand.
	typedef enum logic [1:0] {
		OPRD_REG = 2'd0,
		OPRD_IMM = 2'd1,
		OPRD_MEM = 2'd2,
		OPRD_STACK = 2'd3
	} oprd_kind_t;

	// ext is the base register value, or the stack pointer.
	// value is the displacement or immediate.
	typedef struct packed {
		oprd_kind_t kind;
		logic [`REG_W-1:0] r;
		logic [`MEM_ADDR_W-1:0] ext;
		logic [`MEM_DATA_W-1:0] value;
	} oprd_t;

	typedef struct packed {
		logic [`OPC_W-1:0] opcode;
		oprd_t oprd1; // destination side.
		oprd_t oprd2; // source side.
		logic [`MEM_ADDR_W-1:0] next_rip;
	} micro_op_t;

endpackage

`default_nettype wire
